// File: dv/miniCoreTb.sv
// Self-checking testbench for the mini core pipeline, built and run by run.sh from the file list
`timescale 1ns/1ns
`default_nettype none

`include "miniCoreCfg_cfg.svh"

module miniCoreTb;

    localparam int NumTests      = 5;
    localparam int ProgLen       = 120;
    localparam int TotalInstr    = NumTests * (`MINI_CORE_RF_MSB + ProgLen);
    localparam int TimeoutCycles = TotalInstr * 5 + 100;
    localparam int MaxCycles     = TimeoutCycles + 16;
    localparam int ClkPeriod     = 4;
    // Drive edge to sampling edge of the matching writeback
    localparam int WbLag         = 5;

    logic                        Clock;
    logic                        arstN;
    logic                        instrValidQ100H;
    logic [`MINI_CORE_XLEN-1:0]  instrQ100H;
    logic [`MINI_CORE_XLEN-1:0]  pcQ100H;
    logic                        wbValidQ104H;
    logic [`MINI_CORE_REG_W-1:0] wbDstQ104H;
    logic [`MINI_CORE_XLEN-1:0]  wbDataQ104H;
    logic [`MINI_CORE_XLEN-1:0]  wbPcQ104H;

    integer      seed;
    integer      cycleCnt;
    integer      errCount;
    integer      checkCount;
    logic [31:0] nextPc;
    logic [31:0] shadow [32];
    logic [4:0]  recentDst [4];
    // Expected writeback, indexed by strobe cycle
    logic        expWr   [MaxCycles];
    logic [4:0]  expDst  [MaxCycles];
    logic [31:0] expData [MaxCycles];
    logic [31:0] expPc   [MaxCycles];

    miniCore miniCore_i (
        .Clock           (Clock),
        .arstN           (arstN),
        .instrValidQ100H (instrValidQ100H),
        .instrQ100H      (instrQ100H),
        .pcQ100H         (pcQ100H),
        .wbValidQ104H    (wbValidQ104H),
        .wbDstQ104H      (wbDstQ104H),
        .wbDataQ104H     (wbDataQ104H),
        .wbPcQ104H       (wbPcQ104H)
    );

    initial Clock = 1'b0;
    always #(ClkPeriod / 2) Clock = ~Clock;

    // Edge count shared by stimulus and compare
    always @(posedge Clock) cycleCnt <= cycleCnt + 1;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Sequential semantics, returns the write flag
    function automatic logic refExec(
        input  logic [31:0] regs [32],
        input  logic [31:0] word,
        input  logic [31:0] pc,
        output logic [4:0]  dst,
        output logic [31:0] value,
        output logic [31:0] wbPc
    );
        logic [31:0] a;
        logic [31:0] b;
        logic        known;
        dst   = word[11:7];
        wbPc  = pc;
        a     = regs[word[19:15]];
        b     = '0;
        value = '0;
        known = 1'b1;
        if (word[6:0] == `MINI_CORE_OPC_OP) begin
            b = regs[word[24:20]];
            case ({word[31:25], word[14:12]})
                {7'h00, 3'b000}: value = a + b;
                {7'h20, 3'b000}: value = a - b;
                {7'h00, 3'b111}: value = a & b;
                {7'h00, 3'b110}: value = a | b;
                {7'h00, 3'b100}: value = a ^ b;
                {7'h00, 3'b010}: value = {31'b0, $signed(a) < $signed(b)};
                {7'h00, 3'b001}: value = a << b[4:0];
                {7'h00, 3'b101}: value = a >> b[4:0];
                default:         known = 1'b0;
            endcase
        end else if (word[6:0] == `MINI_CORE_OPC_OPIMM) begin
            b = {{20{word[31]}}, word[31:20]};
            case (word[14:12])
                3'b000:  value = a + b;
                3'b111:  value = a & b;
                3'b110:  value = a | b;
                3'b100:  value = a ^ b;
                3'b010:  value = {31'b0, $signed(a) < $signed(b)};
                default: known = 1'b0;
            endcase
        end else begin
            known = 1'b0;
        end
        return known && (dst != 5'd0);
    endfunction

    task automatic checkEq(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        checkCount = checkCount + 1;
        if (got !== expected) begin
            errCount = errCount + 1;
            $display("ERR %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic idleCycle();
        @(posedge Clock);
        instrValidQ100H <= 1'b0;
    endtask

    task automatic issueInstr(input logic [31:0] word);
        logic        wr;
        logic [4:0]  dst;
        logic [31:0] value;
        logic [31:0] pcOut;
        @(posedge Clock);
        instrValidQ100H <= 1'b1;
        instrQ100H      <= word;
        pcQ100H         <= nextPc;
        wr = refExec(shadow, word, nextPc, dst, value, pcOut);
        expWr[cycleCnt]   = wr;
        expDst[cycleCnt]  = dst;
        expData[cycleCnt] = value;
        expPc[cycleCnt]   = pcOut;
        if (wr) begin
            shadow[dst] = value;
        end
        recentDst[3] = recentDst[2];
        recentDst[2] = recentDst[1];
        recentDst[1] = recentDst[0];
        recentDst[0] = word[11:7];
        nextPc = nextPc + 32'd4;
    endtask

    // Negative gap means 0 to 3 random idle cycles
    task automatic insertGap(input integer gap);
        integer      n;
        logic [31:0] r;
        r = $random(seed);
        n = (gap < 0) ? r % 4 : gap;
        repeat (n) idleCycle();
    endtask

    // Half the sources come from the last four destinations
    task automatic pickSrc(output logic [4:0] src);
        logic [31:0] r;
        r = $random(seed);
        src = r[0] ? recentDst[r[2:1]] : r[7:3];
    endtask

    task automatic makeInstr(output logic [31:0] word);
        logic [31:0] r;
        logic [31:0] immR;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  kind;
        logic [2:0]  f3;
        r    = $random(seed);
        immR = $random(seed);
        kind = r[11:8];
        // Roughly one in eight aimed at x0
        rd   = (r[2:0] == 3'd0) ? 5'd0 : r[7:3];
        f3   = 3'b000;
        pickSrc(rs1);
        pickSrc(rs2);
        if (kind < 4'd8) begin
            case (kind[2:0])
                3'd2:    f3 = 3'b111;
                3'd3:    f3 = 3'b110;
                3'd4:    f3 = 3'b100;
                3'd5:    f3 = 3'b010;
                3'd6:    f3 = 3'b001;
                3'd7:    f3 = 3'b101;
                default: f3 = 3'b000;
            endcase
            // Kind 1 is SUB
            word = {(kind == 4'd1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, `MINI_CORE_OPC_OP};
        end else if (kind < 4'd13) begin
            case (kind)
                4'd9:    f3 = 3'b111;
                4'd10:   f3 = 3'b110;
                4'd11:   f3 = 3'b100;
                4'd12:   f3 = 3'b010;
                default: f3 = 3'b000;
            endcase
            word = {immR[11:0], rs1, f3, rd, `MINI_CORE_OPC_OPIMM};
        end else if (kind == 4'd13) begin
            // Shift immediates and SLTIU lie outside the slice
            f3 = immR[12] ? 3'b001 : (immR[13] ? 3'b011 : 3'b101);
            word = {immR[11:0], rs1, f3, rd, `MINI_CORE_OPC_OPIMM};
        end else if (kind == 4'd14) begin
            // Multiply group funct7
            word = {7'h01, rs2, rs1, immR[14:12], rd, `MINI_CORE_OPC_OP};
        end else begin
            // Load opcode, retires silently
            word = {immR[11:0], rs1, 3'b010, rd, 7'b0000011};
        end
    endtask

    task automatic runTest(input integer testNum, input integer gap);
        integer      errBefore;
        logic [31:0] r;
        logic [31:0] word;
        logic [4:0]  rd;
        errBefore = errCount;
        // Fill x1 to x31 from x0
        rd = 5'd1;
        repeat (`MINI_CORE_RF_MSB) begin
            r = $random(seed);
            issueInstr({r[11:0], 5'd0, 3'b000, rd, `MINI_CORE_OPC_OPIMM});
            insertGap(gap);
            rd = rd + 5'd1;
        end
        repeat (ProgLen) begin
            makeInstr(word);
            issueInstr(word);
            insertGap(gap);
        end
        // Drain the pipe before reporting
        repeat (8) idleCycle();
        if (gap < 0) begin
            $display("test %0d random gaps: %0d instructions, %0d errors",
                     testNum, `MINI_CORE_RF_MSB + ProgLen, errCount - errBefore);
        end else begin
            $display("test %0d gap %0d: %0d instructions, %0d errors",
                     testNum, gap, `MINI_CORE_RF_MSB + ProgLen, errCount - errBefore);
        end
    endtask

    // ----------------------------------------
    // Compare and watchdog
    // ----------------------------------------
    // Reads pre-edge outputs, expectation from WbLag edges back
    initial begin : compareProc
        integer idx;
        logic   expValid;
        forever begin
            @(posedge Clock);
            if (arstN) begin
                idx = cycleCnt - WbLag;
                expValid = (idx >= 0) ? expWr[idx] : 1'b0;
                checkEq("wbValidQ104H", {31'b0, wbValidQ104H}, {31'b0, expValid});
                if (expValid && wbValidQ104H) begin
                    checkEq("wbDstQ104H", {27'b0, wbDstQ104H}, {27'b0, expDst[idx]});
                    checkEq("wbDataQ104H", wbDataQ104H, expData[idx]);
                    checkEq("wbPcQ104H", wbPcQ104H, expPc[idx]);
                end
            end
        end
    end

    initial begin : watchdog
        #(TimeoutCycles * ClkPeriod);
        $display("Simulation timed out after %0d cycles", TimeoutCycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin : mainProc
        integer i;
        integer t;
        seed            = 28801;
        cycleCnt        = 0;
        errCount        = 0;
        checkCount      = 0;
        nextPc          = 32'h0000_1000;
        arstN           = 1'b0;
        instrValidQ100H = 1'b0;
        instrQ100H      = '0;
        pcQ100H         = '0;
        for (i = 0; i < 32; i = i + 1) shadow[i] = '0;
        for (i = 0; i < 4; i = i + 1) recentDst[i] = 5'd1;
        for (i = 0; i < MaxCycles; i = i + 1) begin
            expWr[i]   = 1'b0;
            expDst[i]  = '0;
            expData[i] = '0;
            expPc[i]   = '0;
        end
        repeat (2) @(posedge Clock);
        arstN <= 1'b1;
        // Quiet cycles, writeback must stay low
        repeat (4) idleCycle();
        // Fixed gaps 0 to 3, then random gaps
        for (t = 0; t < NumTests; t = t + 1) begin
            runTest(t, (t < 4) ? t : -1);
        end
        $display("%0d tests, %0d checks, %0d errors", NumTests, checkCount, errCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: include/miniCoreCfg_cfg.svh
// Mini core sizing and opcode constants, included by the package, interface and RTL modules
`ifndef MINI_CORE_CFG_SVH
`define MINI_CORE_CFG_SVH

// ----------------------------------------
// Datapath sizing
// ----------------------------------------
// Integer register and data width
`define MINI_CORE_XLEN 32
// Highest architectural register index
`define MINI_CORE_RF_MSB 31
// Bits needed to name one register
`define MINI_CORE_REG_W 5

// ----------------------------------------
// Major opcodes
// ----------------------------------------
// Register to register group
`define MINI_CORE_OPC_OP 7'b0110011
// Register with immediate group
`define MINI_CORE_OPC_OPIMM 7'b0010011

`endif

// File: miniCore.f
+incdir+include
verilog/miniCorePkg.sv
verilog/miniCoreRfIf.sv
verilog/miniCoreDecode.sv
verilog/miniCoreRf.sv
verilog/miniCoreExe.sv
verilog/miniCore.sv
dv/miniCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the mini core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    -f miniCore.f --top-module miniCoreTb -Mdir obj_dir -o miniCoreTbSim
./obj_dir/miniCoreTbSim | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
    exit 0
else
    exit 1
fi

// File: verilog/miniCore.sv
// Mini core pipeline top, connects decode, register file and execute behind plain ports
`timescale 1ns/1ns
`default_nettype none

`include "miniCoreCfg_cfg.svh"

module miniCore
    import miniCorePkg::*;
(
    input  wire                         Clock,
    input  wire                         arstN,
    input  wire                         instrValidQ100H,
    input  wire [`MINI_CORE_XLEN-1:0]   instrQ100H,
    input  wire [`MINI_CORE_XLEN-1:0]   pcQ100H,
    output logic                        wbValidQ104H,
    output logic [`MINI_CORE_REG_W-1:0] wbDstQ104H,
    output logic [`MINI_CORE_XLEN-1:0]  wbDataQ104H,
    output logic [`MINI_CORE_XLEN-1:0]  wbPcQ104H
);

    // ----------------------------------------
    // Stage to stage wiring
    // ----------------------------------------
    // Decode to register file and execute
    t_exeCtrl                   exeCtrlQ101H;
    logic [`MINI_CORE_XLEN-1:0] pcQ101H;
    logic [`MINI_CORE_XLEN-1:0] immediateQ101H;
    // Register file to execute
    logic [`MINI_CORE_XLEN-1:0] pcQ102H;
    logic [`MINI_CORE_XLEN-1:0] immediateQ102H;
    logic [`MINI_CORE_XLEN-1:0] regRdData1Q102H;
    logic [`MINI_CORE_XLEN-1:0] regRdData2Q102H;

    // Read indexes and writeback port
    miniCoreRfIf rfIf ();

    miniCoreDecode decode_i (
        .Clock           (Clock),
        .arstN           (arstN),
        .instrValidQ100H (instrValidQ100H),
        .instrQ100H      (instrQ100H),
        .pcQ100H         (pcQ100H),
        .exeCtrlQ101H    (exeCtrlQ101H),
        .pcQ101H         (pcQ101H),
        .immediateQ101H  (immediateQ101H),
        .rfIf            (rfIf.decodeMp)
    );

    miniCoreRf rf_i (
        .Clock           (Clock),
        .arstN           (arstN),
        .pcQ101H         (pcQ101H),
        .immediateQ101H  (immediateQ101H),
        .pcQ102H         (pcQ102H),
        .immediateQ102H  (immediateQ102H),
        .regRdData1Q102H (regRdData1Q102H),
        .regRdData2Q102H (regRdData2Q102H),
        .rfIf            (rfIf.rfMp)
    );

    miniCoreExe exe_i (
        .Clock           (Clock),
        .arstN           (arstN),
        .exeCtrlQ101H    (exeCtrlQ101H),
        .pcQ102H         (pcQ102H),
        .immediateQ102H  (immediateQ102H),
        .regRdData1Q102H (regRdData1Q102H),
        .regRdData2Q102H (regRdData2Q102H),
        .wbValidQ104H    (wbValidQ104H),
        .wbDstQ104H      (wbDstQ104H),
        .wbDataQ104H     (wbDataQ104H),
        .wbPcQ104H       (wbPcQ104H),
        .rfIf            (rfIf.exeMp)
    );

endmodule

`default_nettype wire

// File: verilog/miniCoreDecode.sv
// Decode stage, registers the incoming word and builds read indexes, immediate and execute control
`timescale 1ns/1ns
`default_nettype none

`include "miniCoreCfg_cfg.svh"

module miniCoreDecode
    import miniCorePkg::*;
(
    input  wire                        Clock,
    input  wire                        arstN,
    input  wire                        instrValidQ100H,
    input  var t_instr                 instrQ100H,
    input  wire [`MINI_CORE_XLEN-1:0]  pcQ100H,
    output t_exeCtrl                   exeCtrlQ101H,
    output logic [`MINI_CORE_XLEN-1:0] pcQ101H,
    output logic [`MINI_CORE_XLEN-1:0] immediateQ101H,
    miniCoreRfIf.decodeMp              rfIf
);

    logic   validQ101H;
    t_instr instrQ101H;
    logic   isOpQ101H;
    logic   isOpImmQ101H;
    t_aluOp aluOpQ101H;

    // ----------------------------------------
    // Q100H to Q101H registers
    // ----------------------------------------
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            validQ101H <= 1'b0;
        end else begin
            validQ101H <= instrValidQ100H;
        end
    end

    // Word and Pc simply follow the strobe
    always_ff @(posedge Clock) begin
        instrQ101H <= instrQ100H;
        pcQ101H    <= pcQ100H;
    end

    // ----------------------------------------
    // Opcode and funct decode
    // ----------------------------------------
    // Opcode sits in the same bits in both views
    assign isOpQ101H    = (instrQ101H.rFmt.opcode == `MINI_CORE_OPC_OP);
    assign isOpImmQ101H = (instrQ101H.iFmt.opcode == `MINI_CORE_OPC_OPIMM);

    always_comb begin
        aluOpQ101H = ALU_NOP;
        if (isOpQ101H) begin
            case ({instrQ101H.rFmt.funct7, instrQ101H.rFmt.funct3})
                {7'b0000000, 3'b000}: aluOpQ101H = ALU_ADD;
                {7'b0100000, 3'b000}: aluOpQ101H = ALU_SUB;
                {7'b0000000, 3'b111}: aluOpQ101H = ALU_AND;
                {7'b0000000, 3'b110}: aluOpQ101H = ALU_OR;
                {7'b0000000, 3'b100}: aluOpQ101H = ALU_XOR;
                {7'b0000000, 3'b010}: aluOpQ101H = ALU_SLT;
                {7'b0000000, 3'b001}: aluOpQ101H = ALU_SLL;
                {7'b0000000, 3'b101}: aluOpQ101H = ALU_SRL;
                default:              aluOpQ101H = ALU_NOP;
            endcase
        end else if (isOpImmQ101H) begin
            // No shift immediates in this slice
            case (instrQ101H.iFmt.funct3)
                3'b000:  aluOpQ101H = ALU_ADD;
                3'b111:  aluOpQ101H = ALU_AND;
                3'b110:  aluOpQ101H = ALU_OR;
                3'b100:  aluOpQ101H = ALU_XOR;
                3'b010:  aluOpQ101H = ALU_SLT;
                default: aluOpQ101H = ALU_NOP;
            endcase
        end
    end

    // ----------------------------------------
    // Control bundle and immediate
    // ----------------------------------------
    always_comb begin
        exeCtrlQ101H.valid   = validQ101H;
        // Unknown encodings become a NOP without a write
        exeCtrlQ101H.regWrEn = (aluOpQ101H != ALU_NOP);
        // Destination and first source share bits in both views
        exeCtrlQ101H.regDst  = instrQ101H.rFmt.rd;
        exeCtrlQ101H.regSrc1 = instrQ101H.rFmt.rs1;
        // Immediate forms read only one source
        exeCtrlQ101H.regSrc2 = isOpQ101H ? instrQ101H.rFmt.rs2 : '0;
        exeCtrlQ101H.aluOp   = aluOpQ101H;
        exeCtrlQ101H.useImm  = isOpImmQ101H;
    end

    // Sign extended I-type immediate
    assign immediateQ101H = {{(`MINI_CORE_XLEN-12){instrQ101H.iFmt.imm[11]}},
                             instrQ101H.iFmt.imm};

    // Read indexes go straight to the register file
    assign rfIf.regSrc1Q101H = exeCtrlQ101H.regSrc1;
    assign rfIf.regSrc2Q101H = exeCtrlQ101H.regSrc2;

    // Immediate group has no subtract and no right shift
    opImmAluOpOk: assert property (@(posedge Clock) disable iff (!arstN)
        (validQ101H && isOpImmQ101H) |-> !(aluOpQ101H inside {ALU_SUB, ALU_SRL}))
        else $error("OP-IMM decoded to SUB or SRL");

endmodule

`default_nettype wire

// File: verilog/miniCoreExe.sv
// Execute stage with forwarding and ALU, piping the result through Q103H to the Q104H writeback
`timescale 1ns/1ns
`default_nettype none

`include "miniCoreCfg_cfg.svh"

module miniCoreExe
    import miniCorePkg::*;
(
    input  wire                         Clock,
    input  wire                         arstN,
    input  var t_exeCtrl                exeCtrlQ101H,
    input  wire [`MINI_CORE_XLEN-1:0]   pcQ102H,
    input  wire [`MINI_CORE_XLEN-1:0]   immediateQ102H,
    input  wire [`MINI_CORE_XLEN-1:0]   regRdData1Q102H,
    input  wire [`MINI_CORE_XLEN-1:0]   regRdData2Q102H,
    output logic                        wbValidQ104H,
    output logic [`MINI_CORE_REG_W-1:0] wbDstQ104H,
    output logic [`MINI_CORE_XLEN-1:0]  wbDataQ104H,
    output logic [`MINI_CORE_XLEN-1:0]  wbPcQ104H,
    miniCoreRfIf.exeMp                  rfIf
);

    t_exeCtrl                    ctrlQ102H;
    logic                        wrEnQ102H;
    logic [`MINI_CORE_XLEN-1:0]  opAQ102H;
    logic [`MINI_CORE_XLEN-1:0]  fwdData2Q102H;
    logic [`MINI_CORE_XLEN-1:0]  opBQ102H;
    logic [`MINI_CORE_XLEN-1:0]  aluOutQ102H;
    logic                        wrEnQ103H;
    logic [`MINI_CORE_REG_W-1:0] dstQ103H;
    logic [`MINI_CORE_XLEN-1:0]  resultQ103H;
    logic [`MINI_CORE_XLEN-1:0]  pcQ103H;
    logic                        wrEnQ104H;
    logic [`MINI_CORE_REG_W-1:0] dstQ104H;
    logic [`MINI_CORE_XLEN-1:0]  dataQ104H;
    logic [`MINI_CORE_XLEN-1:0]  pcQ104H;

    // ----------------------------------------
    // Control into Q102H
    // ----------------------------------------
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ctrlQ102H <= '0;
        end else begin
            ctrlQ102H <= exeCtrlQ101H;
        end
    end

    // Real write only, x0 dropped here
    assign wrEnQ102H = ctrlQ102H.valid && ctrlQ102H.regWrEn && (ctrlQ102H.regDst != '0);

    // ----------------------------------------
    // Forwarding
    // ----------------------------------------
    // Youngest producer first, then Q104H, then register file
    // A match implies src is not x0 since x0 never gets wrEn
    function automatic logic [`MINI_CORE_XLEN-1:0] fwdSel(
        input logic [`MINI_CORE_REG_W-1:0] src,
        input logic [`MINI_CORE_XLEN-1:0]  rfData
    );
        logic [`MINI_CORE_XLEN-1:0] data;
        if (wrEnQ103H && (src == dstQ103H)) begin
            data = resultQ103H;
        end else if (wrEnQ104H && (src == dstQ104H)) begin
            data = dataQ104H;
        end else begin
            data = rfData;
        end
        return data;
    endfunction

    always_comb begin
        opAQ102H      = fwdSel(ctrlQ102H.regSrc1, regRdData1Q102H);
        fwdData2Q102H = fwdSel(ctrlQ102H.regSrc2, regRdData2Q102H);
        opBQ102H      = ctrlQ102H.useImm ? immediateQ102H : fwdData2Q102H;
    end

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb begin
        case (ctrlQ102H.aluOp)
            ALU_ADD: aluOutQ102H = opAQ102H + opBQ102H;
            ALU_SUB: aluOutQ102H = opAQ102H - opBQ102H;
            ALU_AND: aluOutQ102H = opAQ102H & opBQ102H;
            ALU_OR:  aluOutQ102H = opAQ102H | opBQ102H;
            ALU_XOR: aluOutQ102H = opAQ102H ^ opBQ102H;
            // Signed compare
            ALU_SLT: aluOutQ102H = {{(`MINI_CORE_XLEN-1){1'b0}},
                                    ($signed(opAQ102H) < $signed(opBQ102H))};
            // Shift amount from low 5 bits only
            ALU_SLL: aluOutQ102H = opAQ102H << opBQ102H[4:0];
            ALU_SRL: aluOutQ102H = opAQ102H >> opBQ102H[4:0];
            default: aluOutQ102H = '0;
        endcase
    end

    // ----------------------------------------
    // Q103H and Q104H registers
    // ----------------------------------------
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            wrEnQ103H <= 1'b0;
            wrEnQ104H <= 1'b0;
        end else begin
            wrEnQ103H <= wrEnQ102H;
            wrEnQ104H <= wrEnQ103H;
        end
    end

    always_ff @(posedge Clock) begin
        dstQ103H    <= ctrlQ102H.regDst;
        resultQ103H <= aluOutQ102H;
        pcQ103H     <= pcQ102H;
        dstQ104H    <= dstQ103H;
        dataQ104H   <= resultQ103H;
        pcQ104H     <= pcQ103H;
    end

    // Same registers feed the write port and the wb outputs
    assign rfIf.regWrEnQ104H   = wrEnQ104H;
    assign rfIf.regDstQ104H    = dstQ104H;
    assign rfIf.regWrDataQ104H = dataQ104H;
    assign wbValidQ104H        = wrEnQ104H;
    assign wbDstQ104H          = dstQ104H;
    assign wbDataQ104H         = dataQ104H;
    assign wbPcQ104H           = pcQ104H;

    wbDstKnown: assert property (@(posedge Clock) disable iff (!arstN)
        wbValidQ104H |-> !$isunknown(wbDstQ104H))
        else $error("writeback with unknown destination");

endmodule

`default_nettype wire

// File: verilog/miniCorePkg.sv
// Shared mini core types, imported by decode, execute and the top level
`default_nettype none

`include "miniCoreCfg_cfg.svh"

package miniCorePkg;

    // ----------------------------------------
    // Instruction formats
    // ----------------------------------------
    // Register to register layout
    typedef struct packed {
        logic [6:0]                  funct7;
        logic [`MINI_CORE_REG_W-1:0] rs2;
        logic [`MINI_CORE_REG_W-1:0] rs1;
        logic [2:0]                  funct3;
        logic [`MINI_CORE_REG_W-1:0] rd;
        logic [6:0]                  opcode;
    } t_rFmt;

    // Register with immediate layout
    typedef struct packed {
        logic [11:0]                 imm;
        logic [`MINI_CORE_REG_W-1:0] rs1;
        logic [2:0]                  funct3;
        logic [`MINI_CORE_REG_W-1:0] rd;
        logic [6:0]                  opcode;
    } t_iFmt;

    // One word, two views
    typedef union packed {
        t_rFmt rFmt;
        t_iFmt iFmt;
    } t_instr;

    // ----------------------------------------
    // Execute control
    // ----------------------------------------
    // Immediate forms share the register form ALU codes
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } t_aluOp;

    // Decode to execute bundle at Q101H
    typedef struct packed {
        logic                        valid;
        logic                        regWrEn;
        logic [`MINI_CORE_REG_W-1:0] regDst;
        logic [`MINI_CORE_REG_W-1:0] regSrc1;
        logic [`MINI_CORE_REG_W-1:0] regSrc2;
        t_aluOp                      aluOp;
        logic                        useImm;
    } t_exeCtrl;

endpackage

`default_nettype wire

// File: verilog/miniCoreRf.sv
// Register file stage, reads sources at Q101H with write bypass and registers operands into Q102H
`timescale 1ns/1ns
`default_nettype none

`include "miniCoreCfg_cfg.svh"

module miniCoreRf (
    input  wire                        Clock,
    input  wire                        arstN,
    input  wire [`MINI_CORE_XLEN-1:0]  pcQ101H,
    input  wire [`MINI_CORE_XLEN-1:0]  immediateQ101H,
    output logic [`MINI_CORE_XLEN-1:0] pcQ102H,
    output logic [`MINI_CORE_XLEN-1:0] immediateQ102H,
    output logic [`MINI_CORE_XLEN-1:0] regRdData1Q102H,
    output logic [`MINI_CORE_XLEN-1:0] regRdData2Q102H,
    miniCoreRfIf.rfMp                  rfIf
);

    // x0 has no storage
    logic [`MINI_CORE_RF_MSB:1][`MINI_CORE_XLEN-1:0] regs;
    logic [`MINI_CORE_XLEN-1:0]                      regRdData1Q101H;
    logic [`MINI_CORE_XLEN-1:0]                      regRdData2Q101H;

    // ----------------------------------------
    // Storage write
    // ----------------------------------------
    // Execute already filtered out x0 destinations
    always_ff @(posedge Clock) begin
        if (rfIf.regWrEnQ104H) begin
            regs[rfIf.regDstQ104H] <= rfIf.regWrDataQ104H;
        end
    end

    // ----------------------------------------
    // Read ports
    // ----------------------------------------
    // One read port with x0 and Q104H bypass
    function automatic logic [`MINI_CORE_XLEN-1:0] readPort(
        input logic [`MINI_CORE_REG_W-1:0] src
    );
        logic [`MINI_CORE_XLEN-1:0] data;
        if (src == '0) begin
            data = '0;
        end else if (rfIf.regWrEnQ104H && (src == rfIf.regDstQ104H)) begin
            // Same cycle write not yet in storage
            data = rfIf.regWrDataQ104H;
        end else begin
            data = regs[src];
        end
        return data;
    endfunction

    always_comb begin
        regRdData1Q101H = readPort(rfIf.regSrc1Q101H);
        regRdData2Q101H = readPort(rfIf.regSrc2Q101H);
    end

    // ----------------------------------------
    // Q101H to Q102H registers
    // ----------------------------------------
    // Payload only, advances every cycle
    always_ff @(posedge Clock) begin
        pcQ102H         <= pcQ101H;
        immediateQ102H  <= immediateQ101H;
        regRdData1Q102H <= regRdData1Q101H;
        regRdData2Q102H <= regRdData2Q101H;
    end

    // Write port from execute must name a real register
    wrDstValid: assert property (@(posedge Clock) disable iff (!arstN)
        rfIf.regWrEnQ104H |-> (!$isunknown(rfIf.regDstQ104H) && (rfIf.regDstQ104H != '0)))
        else $error("register write to x0 or unknown index");

endmodule

`default_nettype wire

// File: verilog/miniCoreRfIf.sv
// Register file read indexes and Q104H write port shared by decode, register file and execute
`timescale 1ns/1ns
`default_nettype none

`include "miniCoreCfg_cfg.svh"

interface miniCoreRfIf;

    // Read indexes from decode
    logic [`MINI_CORE_REG_W-1:0] regSrc1Q101H;
    logic [`MINI_CORE_REG_W-1:0] regSrc2Q101H;

    // Write port from execute, never aimed at x0
    logic                        regWrEnQ104H;
    logic [`MINI_CORE_REG_W-1:0] regDstQ104H;
    logic [`MINI_CORE_XLEN-1:0]  regWrDataQ104H;

    modport decodeMp (output regSrc1Q101H, output regSrc2Q101H);

    modport rfMp (input regSrc1Q101H, input regSrc2Q101H,
                  input regWrEnQ104H, input regDstQ104H, input regWrDataQ104H);

    modport exeMp (output regWrEnQ104H, output regDstQ104H, output regWrDataQ104H);

endinterface

`default_nettype wire
